/* csr_unit.f */
rtl/csr_isa_pkg.sv
rtl/csr_unit_pkg.sv
rtl/csr_ctrl.sv
rtl/csr_status_regs.sv
rtl/csr_trap_regs.sv
rtl/csr_counter.sv
rtl/csr_unit_top.sv
verification/tb_clkgen.sv
verification/tb_csr_unit.sv

/* rtl/csr_counter.sv */
module csr_counter
  (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  csr_unit_pkg::csr_sel_s        sel_i,
   input  csr_unit_pkg::csr_wr_s         wr_i,
   output logic [csr_isa_pkg::xlen-1:0]  rdata_o
  );

   import csr_isa_pkg::*;

   logic [xlen-1:0] mcycle_r;

   // Software write takes the place of the increment
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         mcycle_r <= '0;
      else if (wr_i.en && sel_i.mcycle)
         mcycle_r <= wr_i.data;
      else
         mcycle_r <= mcycle_r + xlen'(1);
   end

   assign rdata_o = sel_i.mcycle ? mcycle_r : '0;

endmodule

/* rtl/csr_ctrl.sv */
module csr_ctrl
  (
   input  logic                                   clk_i,
   input  logic                                   rst_n_i,
   input  logic                                   cmd_v_i,
   input  csr_unit_pkg::csr_cmd_s                 cmd_i,
   input  logic                                   exc_v_i,
   input  csr_unit_pkg::exc_s                     exc_i,
   input  logic [csr_unit_pkg::hartid_width-1:0]  hartid_i,
   input  logic [csr_isa_pkg::xlen-1:0]           status_rdata_i,
   input  logic [csr_isa_pkg::xlen-1:0]           trap_rdata_i,
   input  logic [csr_isa_pkg::xlen-1:0]           cycle_rdata_i,
   input  csr_isa_pkg::mstatus_s                  mstatus_i,
   input  logic [csr_isa_pkg::xlen-1:0]           medeleg_i,
   input  logic [csr_isa_pkg::xlen-1:0]           mtvec_i,
   input  logic [csr_isa_pkg::xlen-1:0]           stvec_i,
   input  logic [csr_isa_pkg::xlen-1:0]           mepc_i,
   input  logic [csr_isa_pkg::xlen-1:0]           sepc_i,
   output csr_unit_pkg::csr_sel_s                 sel_o,
   output csr_unit_pkg::csr_wr_s                  wr_o,
   output csr_unit_pkg::trap_s                    trap_o,
   output logic                                   ret_req_o,
   output logic                                   ret_sret_o,
   output csr_unit_pkg::csr_resp_s                resp_o,
   output logic                                   trap_v_o,
   output logic                                   ret_v_o,
   output logic [csr_isa_pkg::vaddr_width-1:0]    epc_o,
   output logic [csr_isa_pkg::vaddr_width-1:0]    tvec_o,
   output csr_isa_pkg::priv_mode_e                priv_mode_o
  );

   import csr_isa_pkg::*;
   import csr_unit_pkg::*;

   csr_op_e         op;
   csr_addr_u       addr;
   csr_sel_s        sel;
   logic            is_ret;
   logic            is_imm;
   logic            writes;
   logic            known;
   logic            illegal;
   logic            cmd_go;
   logic            trap_go;
   logic            ret_go;
   logic            to_s;
   logic [3:0]      ecode;
   logic            ecode_v;
   logic [xlen-1:0] ident_rdata;
   logic [xlen-1:0] old_value;
   logic [xlen-1:0] operand;
   logic [xlen-1:0] new_value;
   priv_mode_e      priv_mode_r;
   priv_mode_e      priv_mode_n;
   logic            resp_v_r;
   logic            resp_illegal_r;
   logic [xlen-1:0] resp_data_r;

   assign op      = cmd_i.op;
   assign addr    = cmd_i.addr;
   assign is_ret  = (op == op_mret) || (op == op_sret);
   assign is_imm  = op inside {op_rwi, op_rsi, op_rci};
   assign operand = is_imm ? xlen'(cmd_i.data[4:0]) : cmd_i.data;

   // Set and clear with a zero operand only read
   assign writes = (op inside {op_rw, op_rwi}) || (!is_ret && (operand != '0));

   // Address decode, identity registers answered here
   always_comb
   begin
      sel         = '0;
      known       = 1'b1;
      ident_rdata = '0;
      if (!is_ret)
      begin
         unique case (addr.raw)
            csr_addr_sstatus:   sel.sstatus  = 1'b1;
            csr_addr_stvec:     sel.stvec    = 1'b1;
            csr_addr_sscratch:  sel.sscratch = 1'b1;
            csr_addr_sepc:      sel.sepc     = 1'b1;
            csr_addr_scause:    sel.scause   = 1'b1;
            csr_addr_stval:     sel.stval    = 1'b1;
            csr_addr_mstatus:   sel.mstatus  = 1'b1;
            csr_addr_medeleg:   sel.medeleg  = 1'b1;
            csr_addr_mtvec:     sel.mtvec    = 1'b1;
            csr_addr_mscratch:  sel.mscratch = 1'b1;
            csr_addr_mepc:      sel.mepc     = 1'b1;
            csr_addr_mcause:    sel.mcause   = 1'b1;
            csr_addr_mtval:     sel.mtval    = 1'b1;
            csr_addr_mcycle:    sel.mcycle   = 1'b1;
            // Writes to misa are ignored
            csr_addr_misa:      ident_rdata  = misa_value;
            csr_addr_mvendorid: ident_rdata  = '0;
            csr_addr_marchid:   ident_rdata  = marchid_value;
            csr_addr_mimpid:    ident_rdata  = mimpid_value;
            csr_addr_mhartid:   ident_rdata  = xlen'(hartid_i);
            default:            known        = 1'b0;
         endcase
      end
   end

   assign old_value = status_rdata_i | trap_rdata_i | cycle_rdata_i | ident_rdata;

   always_comb
   begin
      if (op == op_mret)
         illegal = (priv_mode_r != priv_m);
      else if (op == op_sret)
         illegal = (priv_mode_r < priv_s);
      else
         illegal = !known
                   || (addr.fields.priv > priv_mode_r)
                   || ((addr.fields.access == 2'b11) && writes);
   end

   always_comb
   begin
      unique case (op)
         op_rw, op_rwi: new_value = operand;
         op_rs, op_rsi: new_value = old_value | operand;
         op_rc, op_rci: new_value = old_value & ~operand;
         default:       new_value = old_value;
      endcase
   end

   // Exception beats a command in the same cycle
   assign cmd_go = cmd_v_i && !exc_v_i;
   assign ret_go = cmd_go && is_ret && !illegal;

   assign sel_o      = sel;
   assign wr_o.en    = cmd_go && !is_ret && !illegal && writes;
   assign wr_o.data  = new_value;
   assign ret_req_o  = ret_go;
   assign ret_sret_o = (op == op_sret);

   // Lowest set cause bit wins
   always_comb
   begin
      ecode   = '0;
      ecode_v = 1'b0;
      for (int i = ecode_width - 1; i >= 0; i--)
      begin
         if (exc_i.ecode_dec[i])
         begin
            ecode   = 4'(i);
            ecode_v = 1'b1;
         end
      end
   end

   assign trap_go = exc_v_i && ecode_v;
   assign to_s    = medeleg_i[ecode] && (priv_mode_r == priv_s);

   assign trap_o.valid = trap_go;
   assign trap_o.to_s  = to_s;
   assign trap_o.epc   = exc_i.pc;
   assign trap_o.ecode = ecode;
   assign trap_o.tval  = (ecode == ecode_illegal_instr) ? xlen'(exc_i.instr)
                                                        : xlen'($signed(exc_i.vaddr));

   always_comb
   begin
      priv_mode_n = priv_mode_r;
      if (trap_go)
         priv_mode_n = to_s ? priv_s : priv_m;
      else if (ret_go && (op == op_mret))
         priv_mode_n = (mstatus_i.mpp == priv_m) ? priv_m : priv_s;
      else if (ret_go)
         // No U mode, so SRET always lands in S
         priv_mode_n = priv_s;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         priv_mode_r <= priv_m;
         resp_v_r    <= 1'b0;
         trap_v_o    <= 1'b0;
         ret_v_o     <= 1'b0;
      end
      else
      begin
         priv_mode_r <= priv_mode_n;
         resp_v_r    <= cmd_go;
         trap_v_o    <= trap_go;
         ret_v_o     <= ret_go;
      end
   end

   always_ff @(posedge clk_i)
   begin
      resp_illegal_r <= illegal;
      resp_data_r    <= old_value;
      epc_o          <= (op == op_sret) ? sepc_i[vaddr_width-1:0] : mepc_i[vaddr_width-1:0];
      tvec_o         <= to_s ? stvec_i[vaddr_width-1:0] : mtvec_i[vaddr_width-1:0];
   end

   assign resp_o      = '{valid: resp_v_r, illegal: resp_illegal_r, data: resp_data_r};
   assign priv_mode_o = priv_mode_r;

endmodule

/* rtl/csr_isa_pkg.sv */
package csr_isa_pkg;

   localparam int xlen        = 64;
   localparam int vaddr_width = 39;

   typedef enum logic [1:0] {
      priv_s = 2'd1,
      priv_m = 2'd3
   } priv_mode_e;

   // Standard CSR address fields
   typedef struct packed {
      logic [1:0] access;
      logic [1:0] priv;
      logic [7:0] index;
   } csr_addr_fields_s;

   typedef union packed {
      logic [11:0]      raw;
      csr_addr_fields_s fields;
   } csr_addr_u;

   localparam logic [11:0] csr_addr_sstatus   = 12'h100;
   localparam logic [11:0] csr_addr_stvec     = 12'h105;
   localparam logic [11:0] csr_addr_sscratch  = 12'h140;
   localparam logic [11:0] csr_addr_sepc      = 12'h141;
   localparam logic [11:0] csr_addr_scause    = 12'h142;
   localparam logic [11:0] csr_addr_stval     = 12'h143;
   localparam logic [11:0] csr_addr_mstatus   = 12'h300;
   localparam logic [11:0] csr_addr_misa      = 12'h301;
   localparam logic [11:0] csr_addr_medeleg   = 12'h302;
   localparam logic [11:0] csr_addr_mtvec     = 12'h305;
   localparam logic [11:0] csr_addr_mscratch  = 12'h340;
   localparam logic [11:0] csr_addr_mepc      = 12'h341;
   localparam logic [11:0] csr_addr_mcause    = 12'h342;
   localparam logic [11:0] csr_addr_mtval     = 12'h343;
   localparam logic [11:0] csr_addr_mcycle    = 12'hb00;
   localparam logic [11:0] csr_addr_mvendorid = 12'hf11;
   localparam logic [11:0] csr_addr_marchid   = 12'hf12;
   localparam logic [11:0] csr_addr_mimpid    = 12'hf13;
   localparam logic [11:0] csr_addr_mhartid   = 12'hf14;

   // RV64 mstatus, unused fields kept as plain storage
   typedef struct packed {
      logic [50:0] rsvd_hi;
      logic [1:0]  mpp;
      logic [1:0]  rsvd_vs;
      logic        spp;
      logic        mpie;
      logic        rsvd_ube;
      logic        spie;
      logic        rsvd_upie;
      logic        mie;
      logic        rsvd_2;
      logic        sie;
      logic        rsvd_0;
   } mstatus_s;

   // spp, spie and sie
   localparam logic [xlen-1:0] sstatus_mask = 64'h0000_0000_0000_0122;

   typedef struct packed {
      logic        interrupt;
      logic [58:0] rsvd;
      logic [3:0]  ecode;
   } cause_s;

   localparam logic [3:0] ecode_illegal_instr = 4'd2;

   // MXL of 2, extensions A, I, S and U
   localparam logic [xlen-1:0] misa_value    = {2'b10, 36'b0, 26'h140101};
   localparam logic [xlen-1:0] marchid_value = 64'd13;
   localparam logic [xlen-1:0] mimpid_value  = 64'd1;

endpackage

/* rtl/csr_status_regs.sv */
module csr_status_regs
  (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  csr_unit_pkg::csr_sel_s        sel_i,
   input  csr_unit_pkg::csr_wr_s         wr_i,
   input  csr_unit_pkg::trap_s           trap_i,
   input  logic                          ret_v_i,
   input  logic                          ret_sret_i,
   input  csr_isa_pkg::priv_mode_e       priv_mode_i,
   output logic [csr_isa_pkg::xlen-1:0]  rdata_o,
   output csr_isa_pkg::mstatus_s         mstatus_o,
   output logic [csr_isa_pkg::xlen-1:0]  medeleg_o,
   output logic [csr_isa_pkg::xlen-1:0]  mtvec_o,
   output logic [csr_isa_pkg::xlen-1:0]  stvec_o
  );

   import csr_isa_pkg::*;

   mstatus_s        mstatus_r;
   mstatus_s        mstatus_n;
   logic [xlen-1:0] medeleg_r;
   logic [xlen-1:0] mtvec_r;
   logic [xlen-1:0] stvec_r;
   logic [xlen-1:0] mscratch_r;
   logic [xlen-1:0] sscratch_r;

   always_comb
   begin
      mstatus_n = mstatus_r;
      if (wr_i.en && sel_i.mstatus)
         mstatus_n = wr_i.data;
      else if (wr_i.en && sel_i.sstatus)
         // sstatus writes reach only the S fields
         mstatus_n = (mstatus_r & ~sstatus_mask) | (wr_i.data & sstatus_mask);

      if (trap_i.valid && trap_i.to_s)
      begin
         mstatus_n.spie = mstatus_r.sie;
         mstatus_n.sie  = 1'b0;
         mstatus_n.spp  = priv_mode_i[0];
      end
      else if (trap_i.valid)
      begin
         mstatus_n.mpie = mstatus_r.mie;
         mstatus_n.mie  = 1'b0;
         mstatus_n.mpp  = priv_mode_i;
      end
      else if (ret_v_i && ret_sret_i)
      begin
         mstatus_n.sie  = mstatus_r.spie;
         mstatus_n.spie = 1'b1;
         // M truncated to one bit
         mstatus_n.spp  = 1'b1;
      end
      else if (ret_v_i)
      begin
         mstatus_n.mie  = mstatus_r.mpie;
         mstatus_n.mpie = 1'b1;
         mstatus_n.mpp  = priv_m;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         mstatus_r  <= '0;
         medeleg_r  <= '0;
         mtvec_r    <= '0;
         stvec_r    <= '0;
         mscratch_r <= '0;
         sscratch_r <= '0;
      end
      else
      begin
         mstatus_r <= mstatus_n;
         if (wr_i.en && sel_i.medeleg)
            medeleg_r <= wr_i.data;
         if (wr_i.en && sel_i.mtvec)
            mtvec_r <= wr_i.data;
         if (wr_i.en && sel_i.stvec)
            stvec_r <= wr_i.data;
         if (wr_i.en && sel_i.mscratch)
            mscratch_r <= wr_i.data;
         if (wr_i.en && sel_i.sscratch)
            sscratch_r <= wr_i.data;
      end
   end

   assign rdata_o = ({xlen{sel_i.mstatus}}  & mstatus_r)
                  | ({xlen{sel_i.sstatus}}  & mstatus_r & sstatus_mask)
                  | ({xlen{sel_i.medeleg}}  & medeleg_r)
                  | ({xlen{sel_i.mtvec}}    & mtvec_r)
                  | ({xlen{sel_i.stvec}}    & stvec_r)
                  | ({xlen{sel_i.mscratch}} & mscratch_r)
                  | ({xlen{sel_i.sscratch}} & sscratch_r);

   assign mstatus_o = mstatus_r;
   assign medeleg_o = medeleg_r;
   assign mtvec_o   = mtvec_r;
   assign stvec_o   = stvec_r;

endmodule

/* rtl/csr_trap_regs.sv */
module csr_trap_regs
  (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  csr_unit_pkg::csr_sel_s        sel_i,
   input  csr_unit_pkg::csr_wr_s         wr_i,
   input  csr_unit_pkg::trap_s           trap_i,
   output logic [csr_isa_pkg::xlen-1:0]  rdata_o,
   output logic [csr_isa_pkg::xlen-1:0]  mepc_o,
   output logic [csr_isa_pkg::xlen-1:0]  sepc_o
  );

   import csr_isa_pkg::*;

   cause_s          trap_cause;
   logic [xlen-1:0] trap_epc;
   logic [xlen-1:0] mepc_r;
   logic [xlen-1:0] mcause_r;
   logic [xlen-1:0] mtval_r;
   logic [xlen-1:0] sepc_r;
   logic [xlen-1:0] scause_r;
   logic [xlen-1:0] stval_r;

   // Synchronous exceptions only
   always_comb
   begin
      trap_cause       = '0;
      trap_cause.ecode = trap_i.ecode;
   end

   assign trap_epc = xlen'($signed(trap_i.epc));

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         mepc_r   <= '0;
         mcause_r <= '0;
         mtval_r  <= '0;
         sepc_r   <= '0;
         scause_r <= '0;
         stval_r  <= '0;
      end
      else if (trap_i.valid && trap_i.to_s)
      begin
         sepc_r   <= trap_epc;
         scause_r <= trap_cause;
         stval_r  <= trap_i.tval;
      end
      else if (trap_i.valid)
      begin
         mepc_r   <= trap_epc;
         mcause_r <= trap_cause;
         mtval_r  <= trap_i.tval;
      end
      else if (wr_i.en)
      begin
         if (sel_i.mepc)
            mepc_r <= wr_i.data;
         if (sel_i.mcause)
            mcause_r <= wr_i.data;
         if (sel_i.mtval)
            mtval_r <= wr_i.data;
         if (sel_i.sepc)
            sepc_r <= wr_i.data;
         if (sel_i.scause)
            scause_r <= wr_i.data;
         if (sel_i.stval)
            stval_r <= wr_i.data;
      end
   end

   assign rdata_o = ({xlen{sel_i.mepc}}   & mepc_r)
                  | ({xlen{sel_i.mcause}} & mcause_r)
                  | ({xlen{sel_i.mtval}}  & mtval_r)
                  | ({xlen{sel_i.sepc}}   & sepc_r)
                  | ({xlen{sel_i.scause}} & scause_r)
                  | ({xlen{sel_i.stval}}  & stval_r);

   assign mepc_o = mepc_r;
   assign sepc_o = sepc_r;

endmodule

/* rtl/csr_unit_pkg.sv */
package csr_unit_pkg;

   localparam int hartid_width = 1;
   localparam int ecode_width  = 16;

   typedef enum logic [2:0] {
      op_rw,
      op_rs,
      op_rc,
      op_rwi,
      op_rsi,
      op_rci,
      op_mret,
      op_sret
   } csr_op_e;

   typedef struct packed {
      csr_op_e                         op;
      csr_isa_pkg::csr_addr_u          addr;
      logic [csr_isa_pkg::xlen-1:0]    data;
   } csr_cmd_s;

   // Exception already decoded into a one-hot cause vector
   typedef struct packed {
      logic [csr_isa_pkg::vaddr_width-1:0] pc;
      logic [csr_isa_pkg::vaddr_width-1:0] vaddr;
      logic [31:0]                         instr;
      logic [ecode_width-1:0]              ecode_dec;
   } exc_s;

   // One bit per stored CSR
   typedef struct packed {
      logic sstatus;
      logic stvec;
      logic sscratch;
      logic sepc;
      logic scause;
      logic stval;
      logic mstatus;
      logic medeleg;
      logic mtvec;
      logic mscratch;
      logic mepc;
      logic mcause;
      logic mtval;
      logic mcycle;
   } csr_sel_s;

   typedef struct packed {
      logic                         en;
      logic [csr_isa_pkg::xlen-1:0] data;
   } csr_wr_s;

   typedef struct packed {
      logic                                valid;
      logic                                to_s;
      logic [csr_isa_pkg::vaddr_width-1:0] epc;
      logic [3:0]                          ecode;
      logic [csr_isa_pkg::xlen-1:0]        tval;
   } trap_s;

   typedef struct packed {
      logic                         valid;
      logic                         illegal;
      logic [csr_isa_pkg::xlen-1:0] data;
   } csr_resp_s;

endpackage

/* rtl/csr_unit_top.sv */
module csr_unit_top
  (
   input  logic                                   clk_i,
   input  logic                                   rst_n_i,
   input  logic                                   cmd_v_i,
   input  csr_unit_pkg::csr_cmd_s                 cmd_i,
   input  logic                                   exc_v_i,
   input  csr_unit_pkg::exc_s                     exc_i,
   input  logic [csr_unit_pkg::hartid_width-1:0]  hartid_i,
   output csr_unit_pkg::csr_resp_s                resp_o,
   output logic                                   trap_v_o,
   output logic                                   ret_v_o,
   output logic [csr_isa_pkg::vaddr_width-1:0]    epc_o,
   output logic [csr_isa_pkg::vaddr_width-1:0]    tvec_o,
   output csr_isa_pkg::priv_mode_e                priv_mode_o
  );

   import csr_isa_pkg::*;
   import csr_unit_pkg::*;

   csr_sel_s        sel;
   csr_wr_s         wr;
   trap_s           trap;
   logic            ret_req;
   logic            ret_sret;
   mstatus_s        mstatus;
   logic [xlen-1:0] status_rdata;
   logic [xlen-1:0] trap_rdata;
   logic [xlen-1:0] cycle_rdata;
   logic [xlen-1:0] medeleg;
   logic [xlen-1:0] mtvec;
   logic [xlen-1:0] stvec;
   logic [xlen-1:0] mepc;
   logic [xlen-1:0] sepc;

   csr_ctrl i_csr_ctrl
     (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .cmd_v_i        (cmd_v_i),
      .cmd_i          (cmd_i),
      .exc_v_i        (exc_v_i),
      .exc_i          (exc_i),
      .hartid_i       (hartid_i),
      .status_rdata_i (status_rdata),
      .trap_rdata_i   (trap_rdata),
      .cycle_rdata_i  (cycle_rdata),
      .mstatus_i      (mstatus),
      .medeleg_i      (medeleg),
      .mtvec_i        (mtvec),
      .stvec_i        (stvec),
      .mepc_i         (mepc),
      .sepc_i         (sepc),
      .sel_o          (sel),
      .wr_o           (wr),
      .trap_o         (trap),
      .ret_req_o      (ret_req),
      .ret_sret_o     (ret_sret),
      .resp_o         (resp_o),
      .trap_v_o       (trap_v_o),
      .ret_v_o        (ret_v_o),
      .epc_o          (epc_o),
      .tvec_o         (tvec_o),
      .priv_mode_o    (priv_mode_o)
     );

   csr_status_regs i_csr_status_regs
     (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .sel_i       (sel),
      .wr_i        (wr),
      .trap_i      (trap),
      .ret_v_i     (ret_req),
      .ret_sret_i  (ret_sret),
      .priv_mode_i (priv_mode_o),
      .rdata_o     (status_rdata),
      .mstatus_o   (mstatus),
      .medeleg_o   (medeleg),
      .mtvec_o     (mtvec),
      .stvec_o     (stvec)
     );

   csr_trap_regs i_csr_trap_regs
     (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .sel_i   (sel),
      .wr_i    (wr),
      .trap_i  (trap),
      .rdata_o (trap_rdata),
      .mepc_o  (mepc),
      .sepc_o  (sepc)
     );

   csr_counter i_csr_counter
     (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .sel_i   (sel),
      .wr_i    (wr),
      .rdata_o (cycle_rdata)
     );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f csr_unit.f --top-module tb_csr_unit -o tb_csr_unit_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_csr_unit_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
   exit 0
fi
exit 1

/* verification/tb_clkgen.sv */
module tb_clkgen
  (
   output logic clk_o,
   output logic rst_n_o
  );

   timeunit 1ns;
   timeprecision 1ps;

   localparam int half_period  = 10;
   localparam int reset_cycles = 3;

   initial
   begin
      clk_o = 1'b0;
      forever #half_period clk_o = ~clk_o;
   end

   // Reset held low across the first rising edges
   initial
   begin
      rst_n_o = 1'b0;
      repeat (reset_cycles) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

/* verification/tb_csr_unit.sv */
module tb_csr_unit;

   timeunit 1ns;
   timeprecision 1ps;

   import csr_isa_pkg::*;
   import csr_unit_pkg::*;

   // Test lengths in cycles, two per access plus idle gaps
   localparam int len_reset   = 24;
   localparam int len_rw      = 30;
   localparam int len_sstatus = 12;
   localparam int len_mtrap   = 16;
   localparam int len_deleg   = 36;
   localparam int len_mcycle  = 24;
   localparam int timeout_cycles =
      4 * (len_reset + len_rw + len_sstatus + len_mtrap + len_deleg + len_mcycle);

   logic                        clk;
   logic                        rst_n;
   logic                        cmd_v;
   csr_cmd_s                    cmd;
   logic                        exc_v;
   exc_s                        exc;
   logic [hartid_width-1:0]     hartid;
   csr_resp_s                   resp;
   logic                        trap_v;
   logic                        ret_v;
   logic [vaddr_width-1:0]      epc;
   logic [vaddr_width-1:0]      tvec;
   priv_mode_e                  priv_mode;

   logic [31:0]                 lfsr_state;
   int                          cycle_cnt;
   int                          issue_cycle;
   int                          check_cnt;
   int                          err_cnt;
   logic                        timed_out;
   logic                        rd_illegal;
   logic [xlen-1:0]             rd_data;
   logic                        last_ret_v;
   logic [vaddr_width-1:0]      last_epc;
   logic [vaddr_width-1:0]      last_tvec;
   priv_mode_e                  last_priv;
   logic [xlen-1:0]             scratch_model;
   logic [xlen-1:0]             mtvec_val;

   tb_clkgen i_tb_clkgen
     (
      .clk_o   (clk),
      .rst_n_o (rst_n)
     );

   csr_unit_top i_csr_unit_top
     (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .cmd_v_i     (cmd_v),
      .cmd_i       (cmd),
      .exc_v_i     (exc_v),
      .exc_i       (exc),
      .hartid_i    (hartid),
      .resp_o      (resp),
      .trap_v_o    (trap_v),
      .ret_v_o     (ret_v),
      .epc_o       (epc),
      .tvec_o      (tvec),
      .priv_mode_o (priv_mode)
     );

   // Galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      else
         return s >> 1;
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v          = {v[62:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   function automatic logic [63:0] sext_va(input logic [vaddr_width-1:0] a);
      return {{(64 - vaddr_width){a[vaddr_width-1]}}, a};
   endfunction

   // Expected CSR value after an op
   function automatic logic [63:0] apply_op(input csr_op_e op, input logic [63:0] old,
                                             input logic [63:0] d);
      logic [63:0] imm;
      imm = {59'b0, d[4:0]};
      case (op)
         op_rw:   return d;
         op_rs:   return old | d;
         op_rc:   return old & ~d;
         op_rwi:  return imm;
         op_rsi:  return old | imm;
         op_rci:  return old & ~imm;
         default: return old;
      endcase
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERR %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
                             input logic [63:0] data);
      csr_cmd_s c;
      c.op       = op;
      c.addr.raw = addr;
      c.data     = data;
      @(posedge clk);
      cmd_v <= 1'b1;
      cmd   <= c;
      @(negedge clk);
      issue_cycle = cycle_cnt;
      @(posedge clk);
      cmd_v <= 1'b0;
      @(negedge clk);
      check("resp_o.valid", 64'(resp.valid), 64'd1);
      rd_illegal = resp.illegal;
      rd_data    = resp.data;
      last_ret_v = ret_v;
      last_epc   = epc;
      last_priv  = priv_mode;
   endtask

   task automatic write_csr(input logic [11:0] addr, input logic [63:0] data);
      csr_access(op_rw, addr, data);
      check($sformatf("resp_o.illegal[%h]", addr), 64'(rd_illegal), 64'd0);
   endtask

   task automatic read_csr(input logic [11:0] addr, input logic [63:0] exp);
      csr_access(op_rs, addr, 64'd0);
      check($sformatf("resp_o.illegal[%h]", addr), 64'(rd_illegal), 64'd0);
      check($sformatf("resp_o.data[%h]", addr), rd_data, exp);
   endtask

   task automatic expect_illegal(input csr_op_e op, input logic [11:0] addr,
                                 input logic [63:0] data);
      csr_access(op, addr, data);
      check($sformatf("resp_o.illegal[%h]", addr), 64'(rd_illegal), 64'd1);
   endtask

   task automatic raise_exc(input logic [vaddr_width-1:0] pc,
                            input logic [vaddr_width-1:0] va,
                            input logic [31:0] ins, input logic [15:0] dec);
      exc_s     e;
      csr_cmd_s c;
      e.pc        = pc;
      e.vaddr     = va;
      e.instr     = ins;
      e.ecode_dec = dec;
      // A colliding mscratch write loses to the exception
      c.op       = op_rw;
      c.addr.raw = csr_addr_mscratch;
      c.data     = rand_bits(64);
      @(posedge clk);
      exc_v <= 1'b1;
      exc   <= e;
      cmd_v <= 1'b1;
      cmd   <= c;
      @(posedge clk);
      exc_v <= 1'b0;
      cmd_v <= 1'b0;
      @(negedge clk);
      check("trap_v_o", 64'(trap_v), 64'd1);
      check("resp_o.valid", 64'(resp.valid), 64'd0);
      last_tvec = tvec;
      last_priv = priv_mode;
   endtask

   task automatic verify_reset_state();
      @(negedge clk);
      check("priv_mode_o", 64'(priv_mode), 64'(priv_m));
      read_csr(csr_addr_mstatus, 64'd0);
      read_csr(csr_addr_misa, misa_value);
      read_csr(csr_addr_marchid, marchid_value);
      read_csr(csr_addr_mimpid, mimpid_value);
      read_csr(csr_addr_mvendorid, 64'd0);
      read_csr(csr_addr_mhartid, 64'(hartid));
      expect_illegal(op_rs, 12'h7c0, 64'd0);
      // Read-only space rejects writes
      expect_illegal(op_rw, csr_addr_mhartid, 64'h5);
   endtask

   task automatic exercise_scratch_ops();
      csr_op_e     ops [6];
      logic [63:0] d;
      ops = '{op_rw, op_rs, op_rc, op_rwi, op_rsi, op_rci};
      scratch_model = '0;
      for (int round = 0; round < 2; round++)
      begin
         for (int i = 0; i < 6; i++)
         begin
            d = rand_bits(64);
            csr_access(ops[i], csr_addr_mscratch, d);
            check("resp_o.illegal", 64'(rd_illegal), 64'd0);
            check("resp_o.data", rd_data, scratch_model);
            scratch_model = apply_op(ops[i], scratch_model, d);
         end
      end
      read_csr(csr_addr_mscratch, scratch_model);
   endtask

   task automatic compare_sstatus_view();
      logic [63:0] d;
      logic [63:0] d2;
      d = rand_bits(64);
      write_csr(csr_addr_mstatus, d);
      read_csr(csr_addr_sstatus, d & sstatus_mask);
      d2 = rand_bits(64);
      write_csr(csr_addr_sstatus, d2);
      read_csr(csr_addr_mstatus, (d & ~sstatus_mask) | (d2 & sstatus_mask));
   endtask

   task automatic trap_to_m_and_mret();
      logic [vaddr_width-1:0] pc;
      logic [vaddr_width-1:0] va;
      logic [31:0]            ins;
      mtvec_val = rand_bits(64);
      write_csr(csr_addr_mtvec, mtvec_val);
      pc  = vaddr_width'(rand_bits(vaddr_width));
      va  = vaddr_width'(rand_bits(vaddr_width));
      ins = 32'(rand_bits(32));
      // Bits 2 and 5 set, cause 2 must win
      raise_exc(pc, va, ins, 16'h0024);
      check("tvec_o", 64'(last_tvec), 64'(mtvec_val[vaddr_width-1:0]));
      check("priv_mode_o", 64'(last_priv), 64'(priv_m));
      read_csr(csr_addr_mepc, sext_va(pc));
      read_csr(csr_addr_mcause, 64'd2);
      read_csr(csr_addr_mtval, 64'(ins));
      write_csr(csr_addr_mstatus, (rand_bits(64) & ~64'h1800) | 64'h0800);
      csr_access(op_mret, 12'h000, 64'd0);
      check("resp_o.illegal", 64'(rd_illegal), 64'd0);
      check("ret_v_o", 64'(last_ret_v), 64'd1);
      check("epc_o", 64'(last_epc), 64'(pc));
      check("priv_mode_o", 64'(last_priv), 64'(priv_s));
   endtask

   task automatic delegate_to_s();
      logic [vaddr_width-1:0] pc;
      logic [vaddr_width-1:0] va;
      logic [63:0]            stvec_val;
      // Undelegated page fault from S goes back to M
      raise_exc(vaddr_width'(rand_bits(vaddr_width)), vaddr_width'(rand_bits(vaddr_width)),
                32'(rand_bits(32)), 16'h2000);
      check("tvec_o", 64'(last_tvec), 64'(mtvec_val[vaddr_width-1:0]));
      check("priv_mode_o", 64'(last_priv), 64'(priv_m));
      write_csr(csr_addr_medeleg, 64'h2000);
      stvec_val = rand_bits(64);
      write_csr(csr_addr_stvec, stvec_val);
      write_csr(csr_addr_mstatus, 64'h0800);
      csr_access(op_mret, 12'h000, 64'd0);
      check("priv_mode_o", 64'(last_priv), 64'(priv_s));
      expect_illegal(op_rs, csr_addr_mscratch, 64'd0);
      expect_illegal(op_rw, csr_addr_mscratch, rand_bits(64));
      pc = vaddr_width'(rand_bits(vaddr_width));
      va = vaddr_width'(rand_bits(vaddr_width));
      raise_exc(pc, va, 32'(rand_bits(32)), 16'h2000);
      check("tvec_o", 64'(last_tvec), 64'(stvec_val[vaddr_width-1:0]));
      check("priv_mode_o", 64'(last_priv), 64'(priv_s));
      read_csr(csr_addr_sepc, sext_va(pc));
      read_csr(csr_addr_scause, 64'd13);
      read_csr(csr_addr_stval, sext_va(va));
      expect_illegal(op_mret, 12'h000, 64'd0);
      check("ret_v_o", 64'(last_ret_v), 64'd0);
      check("priv_mode_o", 64'(last_priv), 64'(priv_s));
      csr_access(op_sret, 12'h000, 64'd0);
      check("resp_o.illegal", 64'(rd_illegal), 64'd0);
      check("ret_v_o", 64'(last_ret_v), 64'd1);
      check("epc_o", 64'(last_epc), 64'(pc));
      check("priv_mode_o", 64'(last_priv), 64'(priv_s));
      // Back to M to confirm the blocked write left mscratch alone
      raise_exc(vaddr_width'(rand_bits(vaddr_width)), vaddr_width'(rand_bits(vaddr_width)),
                32'(rand_bits(32)), 16'h0004);
      check("priv_mode_o", 64'(last_priv), 64'(priv_m));
      read_csr(csr_addr_mscratch, scratch_model);
   endtask

   task automatic track_mcycle();
      logic [63:0] w;
      int          write_cycle;
      int          gaps [4];
      gaps = '{0, 1, 3, 6};
      w = rand_bits(64);
      write_csr(csr_addr_mcycle, w);
      write_cycle = issue_cycle;
      for (int i = 0; i < 4; i++)
      begin
         repeat (gaps[i]) @(posedge clk);
         csr_access(op_rs, csr_addr_mcycle, 64'd0);
         check("resp_o.data[mcycle]", rd_data, w + 64'(issue_cycle - write_cycle - 1));
      end
   endtask

   task automatic report_and_finish();
      $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0 && !timed_out)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   endtask

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles)
      begin
         timed_out = 1'b1;
         $display("Timeout: tests did not complete within %0d cycles", timeout_cycles);
         report_and_finish();
      end
   end

   initial
   begin
      cmd_v      = 1'b0;
      cmd        = '0;
      exc_v      = 1'b0;
      exc        = '0;
      hartid     = 1'b1;
      lfsr_state = 32'h8bce2354;
      cycle_cnt  = 0;
      check_cnt  = 0;
      err_cnt    = 0;
      timed_out  = 1'b0;
      @(posedge clk iff rst_n);
      verify_reset_state();
      exercise_scratch_ops();
      compare_sstatus_view();
      trap_to_m_and_mret();
      delegate_to_s();
      track_mcycle();
      report_and_finish();
   end

endmodule
